//--- hw/ber_config.svh
`ifndef BER_CONFIG_SVH
`define BER_CONFIG_SVH

// link word width in bits.
`define BER_WIDTH 128

// number of input bits summed by one leaf of the popcount tree.
`define BER_SLICE 6

// leaf register, one register per adder tree level, one output register.
`define BER_POPCNT_LAT ($clog2((`BER_WIDTH + `BER_SLICE - 1) / `BER_SLICE) + 2)

// errors in one word, 0 to BER_WIDTH inclusive.
`define BER_CNT_W ($clog2(`BER_WIDTH) + 1)

// words in one window.
`define BER_WORDS_W 16

// errors in one window, sized so that a full window of all-bad words fits.
`define BER_ERRS_W 24

`endif

//--- hw/ber_pkg.sv
`include "ber_config.svh"
`default_nettype none

package ber_pkg;

  typedef logic [`BER_WIDTH-1:0]   ber_word_t;
  typedef logic [`BER_CNT_W-1:0]   popcnt_t;
  typedef logic [`BER_WORDS_W-1:0] word_cnt_t;
  typedef logic [`BER_ERRS_W-1:0]  err_cnt_t;

  // PRBS31 shift register, bit 30 is the oldest bit.
  typedef logic [30:0] prbs_state_t;

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } ber_state_e;

  typedef struct packed {
    err_cnt_t  errors;
    word_cnt_t words;
  } ber_result_t;

  typedef struct packed {
    prbs_state_t seed;
    word_cnt_t   window_len;
  } ber_cfg_t;

endpackage

`default_nettype wire

//--- hw/bit_population_counter.sv
`default_nettype none

module bit_population_counter #(
  parameter int WIDTH = 128,
  parameter int SLICE = 6
)(
  input  logic                   clk_i,
  input  logic                   srst_i,
  input  logic [WIDTH-1:0]       data_i,
  input  logic                   data_val_i,

  output logic [$clog2(WIDTH):0] data_o,
  output logic                   data_val_o
);

  localparam int SLICE_CNT = (WIDTH + SLICE - 1) / SLICE;
  localparam int LEVELS    = $clog2(SLICE_CNT);
  localparam int CNT_W     = $clog2(WIDTH) + 1;

  logic [SLICE_CNT-1:0][CNT_W-1:0]          slice_cnt;
  logic [LEVELS:0][SLICE_CNT-1:0][CNT_W-1:0] tree;
  logic [CNT_W-1:0]                         data_q;
  logic [LEVELS+1:0]                        valid_delay;

  // leaf counts, the last slice may be short.
  always_comb
  begin
    for (int i = 0; i < SLICE_CNT; i++)
    begin
      slice_cnt[i] = '0;
      for (int j = 0; j < SLICE && i * SLICE + j < WIDTH; j++)
        slice_cnt[i] = slice_cnt[i] + CNT_W'(data_i[i * SLICE + j]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    tree[0] <= slice_cnt;
  end

  // each level pairs up the nodes of the one below.
  // level n holds ceil(SLICE_CNT / 2^n) nodes, an odd node passes through.
  always_ff @(posedge clk_i)
  begin
    for (int lvl = 1; lvl <= LEVELS; lvl++)
    begin
      for (int i = 0; i < SLICE_CNT; i++)
      begin
        if (2 * i + 1 < ((SLICE_CNT + (1 << (lvl - 1)) - 1) >> (lvl - 1)))
          tree[lvl][i] <= tree[lvl-1][2*i] + tree[lvl-1][2*i+1];
        else if (2 * i < ((SLICE_CNT + (1 << (lvl - 1)) - 1) >> (lvl - 1)))
          tree[lvl][i] <= tree[lvl-1][2*i];
        else
          tree[lvl][i] <= '0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    data_q <= tree[LEVELS][0];
  end

  // one stage per register on the data path.
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      valid_delay <= '0;
    else
      valid_delay <= {valid_delay[LEVELS:0], data_val_i};
  end

  assign data_o     = data_q;
  assign data_val_o = valid_delay[LEVELS+1];

endmodule

`default_nettype wire

//--- hw/prbs_mask_gen.sv
`default_nettype none

module prbs_mask_gen (
  input  logic                 clk_i,
  input  logic                 srst_i,
  input  ber_pkg::prbs_state_t seed_i,
  input  logic                 seed_load_i,
  input  logic                 word_en_i,
  input  ber_pkg::ber_word_t   rx_data_i,

  output ber_pkg::ber_word_t   mask_o,
  output logic                 mask_val_o
);

  ber_pkg::prbs_state_t state_q;
  ber_pkg::prbs_state_t state_next;
  ber_pkg::ber_word_t   expected;
  ber_pkg::ber_word_t   mask_q;
  logic                 mask_val_q;
  logic                 fb;

  // x^31 + x^28 + 1, one new bit per step shifted in at the bottom.
  // the first new bit of a word lands in bit 0 of the expected word.
  always_comb
  begin
    state_next = state_q;
    expected   = '0;
    fb         = 1'b0;
    for (int k = 0; k < $bits(ber_pkg::ber_word_t); k++)
    begin
      fb          = state_next[30] ^ state_next[27];
      expected[k] = fb;
      state_next  = {state_next[29:0], fb};
    end
  end

  // seed wins, the control block never enables a word in the load cycle.
  always_ff @(posedge clk_i)
  begin
    if (seed_load_i)
      state_q <= seed_i;
    else if (word_en_i)
      state_q <= state_next;
  end

  always_ff @(posedge clk_i)
  begin
    if (word_en_i)
      mask_q <= expected ^ rx_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      mask_val_q <= 1'b0;
    else
      mask_val_q <= word_en_i;
  end

  assign mask_o     = mask_q;
  assign mask_val_o = mask_val_q;

endmodule

`default_nettype wire

//--- hw/error_accumulator.sv
`default_nettype none

module error_accumulator (
  input  logic                 clk_i,
  input  logic                 srst_i,
  input  logic                 clear_i,
  input  ber_pkg::popcnt_t     count_i,
  input  logic                 count_val_i,
  input  logic                 last_i,

  output ber_pkg::ber_result_t result_o,
  output logic                 result_val_o
);

  ber_pkg::err_cnt_t    err_sum_q;
  ber_pkg::word_cnt_t   word_sum_q;
  ber_pkg::err_cnt_t    err_total;
  ber_pkg::word_cnt_t   word_total;
  ber_pkg::ber_result_t result_q;
  logic                 result_val_q;
  logic                 window_end;

  // totals including the word on the input this cycle.
  assign err_total  = err_sum_q + ber_pkg::err_cnt_t'(count_i);
  assign word_total = word_sum_q + 1'b1;
  assign window_end = count_val_i && last_i;

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      err_sum_q  <= '0;
      word_sum_q <= '0;
    end
    else if (clear_i || window_end)
    begin
      err_sum_q  <= '0;
      word_sum_q <= '0;
    end
    else if (count_val_i)
    begin
      err_sum_q  <= err_total;
      word_sum_q <= word_total;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (window_end)
    begin
      result_q.errors <= err_total;
      result_q.words  <= word_total;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      result_val_q <= 1'b0;
    else
      result_val_q <= window_end;
  end

  assign result_o     = result_q;
  assign result_val_o = result_val_q;

endmodule

`default_nettype wire

//--- hw/ber_ctrl.sv
`include "ber_config.svh"
`default_nettype none

module ber_ctrl (
  input  logic                 clk_i,
  input  logic                 srst_i,
  input  logic                 start_i,
  input  logic                 stop_i,
  input  ber_pkg::ber_cfg_t    cfg_i,
  input  logic                 rx_val_i,

  output ber_pkg::prbs_state_t seed_o,
  output logic                 seed_load_o,
  output logic                 word_en_o,
  output logic                 last_o,
  output logic                 clear_o,
  output logic                 running_o
);

  ber_pkg::ber_state_e    state_q;
  ber_pkg::word_cnt_t     win_len_q;
  ber_pkg::word_cnt_t     word_cnt_q;
  ber_pkg::word_cnt_t     word_cnt_inc;
  logic                   last_word;
  logic [`BER_POPCNT_LAT:0] last_pipe_q;

  assign running_o = (state_q == ber_pkg::RUN);

  // a word in the start cycle is dropped, the generator is loading its seed.
  assign word_en_o = running_o && rx_val_i && !start_i;

  assign word_cnt_inc = word_cnt_q + 1'b1;
  assign last_word    = word_en_o && (word_cnt_inc == win_len_q);

  assign seed_o      = cfg_i.seed;
  assign seed_load_o = start_i;
  assign clear_o     = start_i;

  // start beats stop when both arrive together.
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      state_q <= ber_pkg::IDLE;
    else if (start_i)
      state_q <= ber_pkg::RUN;
    else if (stop_i)
      state_q <= ber_pkg::IDLE;
  end

  // zero length windows behave as one word windows.
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      win_len_q <= ber_pkg::word_cnt_t'(1);
    else if (start_i)
    begin
      if (cfg_i.window_len == '0)
        win_len_q <= ber_pkg::word_cnt_t'(1);
      else
        win_len_q <= cfg_i.window_len;
    end
  end

  // wraps on the last word so that windows follow each other directly.
  always_ff @(posedge clk_i)
  begin
    if (srst_i || start_i)
      word_cnt_q <= '0;
    else if (word_en_o)
    begin
      if (last_word)
        word_cnt_q <= '0;
      else
        word_cnt_q <= word_cnt_inc;
    end
  end

  // mask register plus popcount latency.
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      last_pipe_q <= '0;
    else
      last_pipe_q <= {last_pipe_q[`BER_POPCNT_LAT-1:0], last_word};
  end

  assign last_o = last_pipe_q[`BER_POPCNT_LAT];

endmodule

`default_nettype wire

//--- hw/ber_top.sv
`include "ber_config.svh"
`default_nettype none

module ber_top (
  input  logic                 clk_i,
  input  logic                 srst_i,
  input  logic                 start_i,
  input  ber_pkg::ber_cfg_t    cfg_i,
  input  logic                 stop_i,
  input  ber_pkg::ber_word_t   rx_data_i,
  input  logic                 rx_val_i,

  output ber_pkg::ber_result_t result_o,
  output logic                 result_val_o,
  output logic                 running_o
);

  ber_pkg::prbs_state_t seed;
  logic                 seed_load;
  logic                 word_en;
  logic                 last;
  logic                 clear;
  ber_pkg::ber_word_t   mask;
  logic                 mask_val;
  ber_pkg::popcnt_t     err_cnt;
  logic                 err_cnt_val;

  ber_ctrl ctrl0 (
    .clk_i       (clk_i),
    .srst_i      (srst_i),
    .start_i     (start_i),
    .stop_i      (stop_i),
    .cfg_i       (cfg_i),
    .rx_val_i    (rx_val_i),
    .seed_o      (seed),
    .seed_load_o (seed_load),
    .word_en_o   (word_en),
    .last_o      (last),
    .clear_o     (clear),
    .running_o   (running_o)
  );

  prbs_mask_gen mask_gen0 (
    .clk_i       (clk_i),
    .srst_i      (srst_i),
    .seed_i      (seed),
    .seed_load_i (seed_load),
    .word_en_i   (word_en),
    .rx_data_i   (rx_data_i),
    .mask_o      (mask),
    .mask_val_o  (mask_val)
  );

  bit_population_counter #(
    .WIDTH (`BER_WIDTH),
    .SLICE (`BER_SLICE)
  ) popcnt0 (
    .clk_i      (clk_i),
    .srst_i     (srst_i),
    .data_i     (mask),
    .data_val_i (mask_val),
    .data_o     (err_cnt),
    .data_val_o (err_cnt_val)
  );

  error_accumulator acc0 (
    .clk_i        (clk_i),
    .srst_i       (srst_i),
    .clear_i      (clear),
    .count_i      (err_cnt),
    .count_val_i  (err_cnt_val),
    .last_i       (last),
    .result_o     (result_o),
    .result_val_o (result_val_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_ber_ref.svh
`ifndef TB_BER_REF_SVH
`define TB_BER_REF_SVH

task automatic fail_run();
  $display("Test failures found");
  $fatal(1);
endtask

// expected word for one enabled word, the first generated bit lands in bit 0.
function automatic ber_pkg::ber_word_t prbs31_word(
  input  ber_pkg::prbs_state_t cur,
  output ber_pkg::prbs_state_t next
);
  ber_pkg::prbs_state_t s;
  ber_pkg::ber_word_t   w;
  logic                 b;
  s = cur;
  w = '0;
  for (int k = 0; k < `BER_WIDTH; k++)
  begin
    // taps 31 and 28 of x^31 + x^28 + 1.
    b    = s[30] ^ s[27];
    w[k] = b;
    s    = {s[29:0], b};
  end
  next = s;
  return w;
endfunction

function automatic ber_pkg::popcnt_t count_ones(input ber_pkg::ber_word_t w);
  ber_pkg::popcnt_t n;
  n = '0;
  for (int k = 0; k < `BER_WIDTH; k++)
    n = n + ber_pkg::popcnt_t'(w[k]);
  return n;
endfunction

task automatic check_result(
  input ber_pkg::ber_result_t got,
  input ber_pkg::ber_result_t exp
);
  if (got !== exp)
  begin
    $display("ERR %0t window result errors %0d words %0d, expected errors %0d words %0d",
             $time, got.errors, got.words, exp.errors, exp.words);
    fail_run();
  end
endtask

task automatic check_latency(input int got, input int exp);
  if (got != exp)
  begin
    $display("ERR %0t result latency %0d cycles, expected %0d", $time, got, exp);
    fail_run();
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp)
  begin
    $display("ERR %0t %s is %b, expected %b", $time, what, got, exp);
    fail_run();
  end
endtask

`endif

//--- verification/tb_ber_top.sv
`include "ber_config.svh"
`default_nettype none

module tb_ber_top;

  localparam int RESULT_LAT = 9;
  localparam int WAIT_LIMIT = 1000;
  localparam int WINDOWS    = 10;

  logic                 clk;
  logic                 srst;
  logic                 start;
  logic                 stop;
  ber_pkg::ber_cfg_t    cfg;
  ber_pkg::ber_word_t   rx_data;
  logic                 rx_val;
  ber_pkg::ber_result_t result;
  logic                 result_val;
  logic                 running;

  int                   rand_seed = 20;
  int                   cyc = 0;
  int                   result_cnt = 0;
  ber_pkg::prbs_state_t ref_state;
  ber_pkg::word_cnt_t   ref_len;
  ber_pkg::word_cnt_t   ref_words;
  ber_pkg::err_cnt_t    ref_errs;
  ber_pkg::ber_result_t exp_q[$];
  int                   drive_cyc_q[$];

  `include "tb_ber_ref.svh"

  ber_top dut0 (
    .clk_i        (clk),
    .srst_i       (srst),
    .start_i      (start),
    .cfg_i        (cfg),
    .stop_i       (stop),
    .rx_data_i    (rx_data),
    .rx_val_i     (rx_val),
    .result_o     (result),
    .result_val_o (result_val),
    .running_o    (running)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  function automatic ber_pkg::ber_word_t random_word();
    return {$random(rand_seed), $random(rand_seed), $random(rand_seed), $random(rand_seed)};
  endfunction

  function automatic ber_pkg::prbs_state_t random_state();
    ber_pkg::prbs_state_t s;
    s = ber_pkg::prbs_state_t'($random(rand_seed));
    if (s == '0)
      s = 31'h1;
    return s;
  endfunction

  // flip masks are none, all, dense or sparse.
  function automatic ber_pkg::ber_word_t random_flips();
    int mode;
    mode = $random(rand_seed) & 3;
    if (mode == 0)
      return '0;
    else if (mode == 1)
      return '1;
    else if (mode == 2)
      return random_word();
    else
      return random_word() & random_word() & random_word();
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
    start  = 1'b0;
    stop   = 1'b0;
    rx_val = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
      next_cycle();
  endtask

  task automatic start_run(input ber_pkg::prbs_state_t seed, input ber_pkg::word_cnt_t len);
    next_cycle();
    start          = 1'b1;
    cfg.seed       = seed;
    cfg.window_len = len;
    ref_state      = seed;
    ref_len        = (len == '0) ? ber_pkg::word_cnt_t'(1) : len;
    ref_words      = '0;
    ref_errs       = '0;
  endtask

  task automatic stop_run();
    next_cycle();
    stop = 1'b1;
  endtask

  // a word the checker is expected to ignore.
  task automatic send_stray_word();
    next_cycle();
    rx_data = random_word();
    rx_val  = 1'b1;
  endtask

  task automatic send_word(input ber_pkg::ber_word_t flips);
    ber_pkg::ber_word_t   expected;
    ber_pkg::prbs_state_t next_state;
    ber_pkg::ber_result_t res;
    next_cycle();
    check_bit(running, 1'b1, "running_o");
    expected  = prbs31_word(ref_state, next_state);
    ref_state = next_state;
    rx_data   = expected ^ flips;
    rx_val    = 1'b1;
    ref_errs  = ref_errs + ber_pkg::err_cnt_t'(count_ones(flips));
    ref_words = ref_words + ber_pkg::word_cnt_t'(1);
    if (ref_words == ref_len)
    begin
      res.errors = ref_errs;
      res.words  = ref_words;
      exp_q.push_back(res);
      drive_cyc_q.push_back(cyc);
      ref_words = '0;
      ref_errs  = '0;
    end
  endtask

  task automatic send_window(input bit gaps, input bit with_errors, input bit all_ones_first);
    ber_pkg::word_cnt_t len;
    len = ref_len;
    for (int i = 0; i < int'(len); i++)
    begin
      if (!with_errors)
        send_word('0);
      else if (i == 0 && all_ones_first)
        send_word('1);
      else
        send_word(random_flips());
      if (gaps)
        idle_cycles(int'($unsigned($random(rand_seed)) % 3));
    end
  endtask

  // the scoreboard samples outputs away from the rising edge.
  initial
  begin
    ber_pkg::ber_result_t exp_res;
    forever
    begin
      @(negedge clk);
      if (result_val === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          $display("result strobe at time %0t with no window outstanding", $time);
          fail_run();
        end
        else
        begin
          exp_res = exp_q.pop_front();
          check_result(result, exp_res);
          check_latency(cyc - drive_cyc_q.pop_front(), RESULT_LAT);
          result_cnt++;
        end
      end
    end
  end

  initial
  begin
    srst    = 1'b1;
    start   = 1'b0;
    stop    = 1'b0;
    cfg     = '0;
    rx_data = '0;
    rx_val  = 1'b0;
    idle_cycles(5);
    srst = 1'b0;

    // stray words before any start must not count.
    for (int i = 0; i < 20; i++)
    begin
      if (i % 3 == 1)
        send_stray_word();
      else
        next_cycle();
      check_bit(running, 1'b0, "running_o");
      check_bit(result_val, 1'b0, "result_val_o");
    end

    start_run(random_state(), ber_pkg::word_cnt_t'(8));
    for (int w = 0; w < 4; w++)
      send_window(1'b1, 1'b0, 1'b0);

    // errored windows with the first two back to back.
    send_window(1'b0, 1'b1, 1'b1);
    send_window(1'b0, 1'b1, 1'b0);
    send_window(1'b1, 1'b1, 1'b0);
    send_window(1'b1, 1'b1, 1'b1);

    // a partial window and a stop, then words while idle and a fresh run.
    for (int i = 0; i < 5; i++)
      send_word(random_flips());
    stop_run();
    for (int i = 0; i < 4; i++)
    begin
      send_stray_word();
      check_bit(running, 1'b0, "running_o");
    end
    // let the stopped words leave the pipeline before the restart.
    idle_cycles(RESULT_LAT);
    start_run(random_state(), ber_pkg::word_cnt_t'(3));
    send_window(1'b1, 1'b1, 1'b0);
    send_window(1'b0, 1'b1, 1'b1);
    next_cycle();

    for (int t = 0; exp_q.size() != 0; t++)
    begin
      if (t >= WAIT_LIMIT)
      begin
        $display("timed out waiting for %0d window results", exp_q.size());
        fail_run();
      end
      next_cycle();
    end
    idle_cycles(20);

    if (result_cnt == WINDOWS)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      $display("saw %0d window results but %0d were sent", result_cnt, WINDOWS);
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
+incdir+verification
hw/ber_pkg.sv
hw/bit_population_counter.sv
hw/prbs_mask_gen.sv
hw/error_accumulator.sv
hw/ber_ctrl.sv
hw/ber_top.sv
verification/tb_ber_top.sv

//--- run.sh
#!/bin/sh
# Build and run the BER checker testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal -f flist.f --top-module tb_ber_top -o tb_ber_top
./obj_dir/tb_ber_top
